// ==== design/noc_bridge_params.svh ====
`ifndef NOC_BRIDGE_PARAMS_SVH
`define NOC_BRIDGE_PARAMS_SVH

// AXI side widths
`define NOC_ADDR_WIDTH 16
`define NOC_DATA_WIDTH 32
`define NOC_ID_WIDTH   4

// One flit carries a single 40-bit word plus sideband
`define NOC_FLIT_WIDTH 40

// --------------------
// Mesh geometry
// --------------------
`define NOC_MESH_X 4
`define NOC_MESH_Y 4

`define NOC_COORD_X_WIDTH ($clog2(`NOC_MESH_X))
`define NOC_COORD_Y_WIDTH ($clog2(`NOC_MESH_Y))

// Byte lanes of one data beat
`define NOC_STRB_WIDTH (`NOC_DATA_WIDTH / 8)

`endif

// ==== design/noc_bridge_pkg.sv ====
`default_nettype none

`include "noc_bridge_params.svh"

package noc_bridge_pkg;

    // Carried on the stream TID field
    typedef enum logic [2:0] {
        ROUTING_HEADER = 3'd0,
        AW_SUBHEADER   = 3'd1,
        W_DATA         = 3'd2,
        B_SUBHEADER    = 3'd3
    } flit_kind_e;

    // --------------------
    // Flit payload layouts
    // --------------------
    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-(8+(`NOC_COORD_X_WIDTH+`NOC_COORD_Y_WIDTH)*2)-1:0] reserved;
        logic [7:0]                    packet_count; // Flits that follow the header
        logic [`NOC_COORD_X_WIDTH-1:0] src_x;
        logic [`NOC_COORD_Y_WIDTH-1:0] src_y;
        logic [`NOC_COORD_X_WIDTH-1:0] dst_x;
        logic [`NOC_COORD_Y_WIDTH-1:0] dst_y;
    } routing_header_t;

    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-(`NOC_ID_WIDTH+`NOC_ADDR_WIDTH+8+3+2)-1:0] reserved;
        logic [`NOC_ID_WIDTH-1:0]   id;
        logic [`NOC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } aw_subheader_t;

    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-`NOC_DATA_WIDTH-1:0] reserved;
        logic [`NOC_DATA_WIDTH-1:0]                 data;
    } w_data_t;

    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-`NOC_ID_WIDTH-1:0] reserved;
        logic [`NOC_ID_WIDTH-1:0]                 id;
    } b_subheader_t;

    // The same word read four ways, selected by the flit kind
    typedef union packed {
        routing_header_t hdr;
        aw_subheader_t   aw;
        w_data_t         w;
        b_subheader_t    b;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_e                 kind;
        flit_payload_u              payload;
        logic [`NOC_STRB_WIDTH-1:0] strb;
        logic                       last;
    } flit_t;

    // --------------------
    // AXI channel payloads
    // --------------------
    typedef struct packed {
        logic [`NOC_ID_WIDTH-1:0]   id;
        logic [`NOC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0] data;
        logic [`NOC_STRB_WIDTH-1:0] strb;
        logic                       last;
    } axi_w_t;

    typedef struct packed {
        logic [`NOC_ID_WIDTH-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [`NOC_COORD_X_WIDTH-1:0] x;
        logic [`NOC_COORD_Y_WIDTH-1:0] y;
    } coord_t;

endpackage

`default_nettype wire

// ==== design/write_req_packetizer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_bridge_params.svh"

module write_req_packetizer #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  wire                           ACLK,
    input  wire                           ARESETn,

    input  wire noc_bridge_pkg::axi_aw_t  aw_i,
    input  wire                           aw_valid_i,
    output logic                          aw_ready_o,

    input  wire noc_bridge_pkg::axi_w_t   w_i,
    input  wire                           w_valid_i,
    output logic                          w_ready_o,

    output noc_bridge_pkg::flit_t         flit_o,
    output logic                          flit_valid_o,
    input  wire                           flit_ready_i
);

    typedef enum logic [1:0] {
        S_HEADER,
        S_ADDR,
        S_DATA
    } state_e;

    state_e state_q, state_d;

    noc_bridge_pkg::routing_header_t hdr;
    noc_bridge_pkg::aw_subheader_t   aw_sub;
    logic [`NOC_ID_WIDTH-1:0]        node_idx;

    assign node_idx = aw_i.id - 1'b1; // IDs count nodes from 1

    always_comb begin
        hdr = '0;
        hdr.dst_x        = `NOC_COORD_X_WIDTH'(node_idx % `NOC_MESH_X);
        hdr.dst_y        = `NOC_COORD_Y_WIDTH'(node_idx / `NOC_MESH_X);
        hdr.src_x        = `NOC_COORD_X_WIDTH'(ROUTER_X);
        hdr.src_y        = `NOC_COORD_Y_WIDTH'(ROUTER_Y);
        hdr.packet_count = aw_i.len + 8'd2; // Subheader plus len+1 beats

        aw_sub = '0;
        aw_sub.id    = aw_i.id;
        aw_sub.addr  = aw_i.addr;
        aw_sub.len   = aw_i.len;
        aw_sub.size  = aw_i.size;
        aw_sub.burst = aw_i.burst;
    end

    // --------------------
    // Packet FSM
    // --------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= S_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        flit_o       = '0;
        flit_valid_o = 1'b0;
        aw_ready_o   = 1'b0;
        w_ready_o    = 1'b0;

        case (state_q)
            S_HEADER: begin
                // AW is only looked at here, it is accepted with the subheader
                flit_o.kind        = noc_bridge_pkg::ROUTING_HEADER;
                flit_o.payload.hdr = hdr;
                flit_o.strb        = '1;
                flit_valid_o       = aw_valid_i;
                if (aw_valid_i && flit_ready_i) begin
                    state_d = S_ADDR;
                end
            end
            S_ADDR: begin
                flit_o.kind       = noc_bridge_pkg::AW_SUBHEADER;
                flit_o.payload.aw = aw_sub;
                flit_o.strb       = '1;
                flit_valid_o      = aw_valid_i;
                aw_ready_o        = flit_ready_i;
                if (aw_valid_i && flit_ready_i) begin
                    state_d = S_DATA;
                end
            end
            S_DATA: begin
                flit_o.kind           = noc_bridge_pkg::W_DATA;
                flit_o.payload.w.data = w_i.data;
                flit_o.strb           = w_i.strb;
                flit_o.last           = w_i.last;
                flit_valid_o          = w_valid_i;
                w_ready_o             = flit_ready_i;
                if (w_valid_i && flit_ready_i && w_i.last) begin
                    state_d = S_HEADER;
                end
            end
            default: begin
                state_d = S_HEADER;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/write_req_depacketizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_req_depacketizer (
    input  wire                           ACLK,
    input  wire                           ARESETn,

    input  wire noc_bridge_pkg::flit_t    flit_i,
    input  wire                           flit_valid_i,
    output logic                          flit_ready_o,

    output noc_bridge_pkg::axi_aw_t       aw_o,
    output logic                          aw_valid_o,
    input  wire                           aw_ready_i,

    output noc_bridge_pkg::axi_w_t        w_o,
    output logic                          w_valid_o,
    input  wire                           w_ready_i,

    output noc_bridge_pkg::coord_t        return_coord_o
);

    noc_bridge_pkg::coord_t src_q;    // Sender of the packet in flight
    noc_bridge_pkg::coord_t return_q;

    // --------------------
    // Flit decode
    // --------------------
    always_comb begin
        flit_ready_o = 1'b1; // Headers and unknown kinds are taken at once
        aw_o         = '0;
        aw_valid_o   = 1'b0;
        w_o          = '0;
        w_valid_o    = 1'b0;

        if (flit_valid_i) begin
            case (flit_i.kind)
                noc_bridge_pkg::AW_SUBHEADER: begin
                    aw_valid_o   = 1'b1;
                    aw_o.id      = flit_i.payload.aw.id;
                    aw_o.addr    = flit_i.payload.aw.addr;
                    aw_o.len     = flit_i.payload.aw.len;
                    aw_o.size    = flit_i.payload.aw.size;
                    aw_o.burst   = flit_i.payload.aw.burst;
                    flit_ready_o = aw_ready_i;
                end
                noc_bridge_pkg::W_DATA: begin
                    w_valid_o    = 1'b1;
                    w_o.data     = flit_i.payload.w.data;
                    w_o.strb     = flit_i.strb;
                    w_o.last     = flit_i.last;
                    flit_ready_o = w_ready_i;
                end
                default: begin
                    flit_ready_o = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            src_q    <= '0;
            return_q <= '0;
        end else begin
            if (flit_valid_i && flit_i.kind == noc_bridge_pkg::ROUTING_HEADER) begin
                src_q.x <= flit_i.payload.hdr.src_x;
                src_q.y <= flit_i.payload.hdr.src_y;
            end
            // The write response goes back to whoever issued this AW
            if (aw_valid_o && aw_ready_i) begin
                return_q <= src_q;
            end
        end
    end

    assign return_coord_o = return_q;

endmodule

`default_nettype wire

// ==== design/write_resp_packetizer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_bridge_params.svh"

module write_resp_packetizer #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  wire                           ACLK,
    input  wire                           ARESETn,

    input  wire noc_bridge_pkg::axi_b_t   b_i,
    input  wire                           b_valid_i,
    output logic                          b_ready_o,

    input  wire noc_bridge_pkg::coord_t   return_coord_i,

    output noc_bridge_pkg::flit_t         flit_o,
    output logic                          flit_valid_o,
    input  wire                           flit_ready_i
);

    typedef enum logic {
        S_HEADER,
        S_RESP
    } state_e;

    state_e state_q, state_d;

    noc_bridge_pkg::routing_header_t hdr;

    always_comb begin
        hdr = '0;
        hdr.dst_x        = return_coord_i.x;
        hdr.dst_y        = return_coord_i.y;
        hdr.src_x        = `NOC_COORD_X_WIDTH'(ROUTER_X);
        hdr.src_y        = `NOC_COORD_Y_WIDTH'(ROUTER_Y);
        hdr.packet_count = 8'd1; // Only the response subheader follows
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= S_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        flit_o       = '0;
        flit_o.strb  = '1;
        flit_valid_o = b_valid_i;
        b_ready_o    = 1'b0;

        if (state_q == S_HEADER) begin
            flit_o.kind        = noc_bridge_pkg::ROUTING_HEADER;
            flit_o.payload.hdr = hdr;
            if (b_valid_i && flit_ready_i) begin
                state_d = S_RESP;
            end
        end else begin
            flit_o.kind           = noc_bridge_pkg::B_SUBHEADER;
            flit_o.payload.b.id   = b_i.id;
            flit_o.last           = 1'b1;
            b_ready_o             = flit_ready_i;
            if (b_valid_i && flit_ready_i) begin
                state_d = S_HEADER;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/write_resp_depacketizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_resp_depacketizer (
    input  wire                           flit_valid_i,
    input  wire noc_bridge_pkg::flit_t    flit_i,
    output logic                          flit_ready_o,

    output noc_bridge_pkg::axi_b_t        b_o,
    output logic                          b_valid_o,
    input  wire                           b_ready_i
);

    // Purely combinational, the header carries nothing the local master needs
    always_comb begin
        flit_ready_o = 1'b1;
        b_o          = '0;
        b_valid_o    = 1'b0;

        if (flit_valid_i && flit_i.kind == noc_bridge_pkg::B_SUBHEADER) begin
            b_valid_o    = 1'b1;
            b_o.id       = flit_i.payload.b.id;
            flit_ready_o = b_ready_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/axi_noc_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_noc_bridge #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  wire                           ACLK,
    input  wire                           ARESETn,

    // Local AXI slave, writes leave this node
    input  wire noc_bridge_pkg::axi_aw_t  s_aw_i,
    input  wire                           s_aw_valid_i,
    output logic                          s_aw_ready_o,
    input  wire noc_bridge_pkg::axi_w_t   s_w_i,
    input  wire                           s_w_valid_i,
    output logic                          s_w_ready_o,
    output noc_bridge_pkg::axi_b_t        s_b_o,
    output logic                          s_b_valid_o,
    input  wire                           s_b_ready_i,

    // Local AXI master, writes arriving from the mesh
    output noc_bridge_pkg::axi_aw_t       m_aw_o,
    output logic                          m_aw_valid_o,
    input  wire                           m_aw_ready_i,
    output noc_bridge_pkg::axi_w_t        m_w_o,
    output logic                          m_w_valid_o,
    input  wire                           m_w_ready_i,
    input  wire noc_bridge_pkg::axi_b_t   m_b_i,
    input  wire                           m_b_valid_i,
    output logic                          m_b_ready_o,

    // --------------------
    // Mesh side streams
    // --------------------
    output noc_bridge_pkg::flit_t         req_flit_o,
    output logic                          req_flit_valid_o,
    input  wire                           req_flit_ready_i,
    input  wire noc_bridge_pkg::flit_t    req_flit_i,
    input  wire                           req_flit_valid_i,
    output logic                          req_flit_ready_o,

    output noc_bridge_pkg::flit_t         resp_flit_o,
    output logic                          resp_flit_valid_o,
    input  wire                           resp_flit_ready_i,
    input  wire noc_bridge_pkg::flit_t    resp_flit_i,
    input  wire                           resp_flit_valid_i,
    output logic                          resp_flit_ready_o
);

    noc_bridge_pkg::coord_t return_coord; // Sender of the last accepted AW

    write_req_packetizer #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_req_packetizer (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .aw_i         (s_aw_i),
        .aw_valid_i   (s_aw_valid_i),
        .aw_ready_o   (s_aw_ready_o),
        .w_i          (s_w_i),
        .w_valid_i    (s_w_valid_i),
        .w_ready_o    (s_w_ready_o),
        .flit_o       (req_flit_o),
        .flit_valid_o (req_flit_valid_o),
        .flit_ready_i (req_flit_ready_i)
    );

    write_req_depacketizer u_req_depacketizer (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .flit_i         (req_flit_i),
        .flit_valid_i   (req_flit_valid_i),
        .flit_ready_o   (req_flit_ready_o),
        .aw_o           (m_aw_o),
        .aw_valid_o     (m_aw_valid_o),
        .aw_ready_i     (m_aw_ready_i),
        .w_o            (m_w_o),
        .w_valid_o      (m_w_valid_o),
        .w_ready_i      (m_w_ready_i),
        .return_coord_o (return_coord)
    );

    write_resp_packetizer #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_resp_packetizer (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .b_i            (m_b_i),
        .b_valid_i      (m_b_valid_i),
        .b_ready_o      (m_b_ready_o),
        .return_coord_i (return_coord),
        .flit_o         (resp_flit_o),
        .flit_valid_o   (resp_flit_valid_o),
        .flit_ready_i   (resp_flit_ready_i)
    );

    write_resp_depacketizer u_resp_depacketizer (
        .flit_i       (resp_flit_i),
        .flit_valid_i (resp_flit_valid_i),
        .flit_ready_o (resp_flit_ready_o),
        .b_o          (s_b_o),
        .b_valid_o    (s_b_valid_o),
        .b_ready_i    (s_b_ready_i)
    );

endmodule

`default_nettype wire

// ==== verification/tb_axi_noc_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_bridge_params.svh"

module tb_axi_noc_bridge;

    localparam int NUM_WRITES = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int ROUTER_X   = 1;
    localparam int ROUTER_Y   = 2;
    localparam int HDR_W      = 2 * (`NOC_COORD_X_WIDTH + `NOC_COORD_Y_WIDTH) + 8;

    // Response header goes back to this node and comes from it too
    localparam logic [HDR_W-1:0] RESP_HDR = {
        ROUTER_X[`NOC_COORD_X_WIDTH-1:0], ROUTER_Y[`NOC_COORD_Y_WIDTH-1:0],
        ROUTER_X[`NOC_COORD_X_WIDTH-1:0], ROUTER_Y[`NOC_COORD_Y_WIDTH-1:0], 8'd1
    };

    logic ACLK;
    logic ARESETn;

    noc_bridge_pkg::axi_aw_t s_aw_i;
    logic                    s_aw_valid_i;
    logic                    s_aw_ready_o;
    noc_bridge_pkg::axi_w_t  s_w_i;
    logic                    s_w_valid_i;
    logic                    s_w_ready_o;
    noc_bridge_pkg::axi_b_t  s_b_o;
    logic                    s_b_valid_o;
    logic                    s_b_ready_i;
    noc_bridge_pkg::axi_aw_t m_aw_o;
    logic                    m_aw_valid_o;
    logic                    m_aw_ready_i;
    noc_bridge_pkg::axi_w_t  m_w_o;
    logic                    m_w_valid_o;
    logic                    m_w_ready_i;
    noc_bridge_pkg::axi_b_t  m_b_i;
    logic                    m_b_valid_i;
    logic                    m_b_ready_o;
    noc_bridge_pkg::flit_t   req_flit_o;
    logic                    req_flit_valid_o;
    logic                    req_flit_ready_i;
    noc_bridge_pkg::flit_t   req_flit_i;
    logic                    req_flit_valid_i;
    logic                    req_flit_ready_o;
    noc_bridge_pkg::flit_t   resp_flit_o;
    logic                    resp_flit_valid_o;
    logic                    resp_flit_ready_i;
    noc_bridge_pkg::flit_t   resp_flit_i;
    logic                    resp_flit_valid_i;
    logic                    resp_flit_ready_o;

    logic req_gate;
    logic resp_gate;

    // Expected values of the write in flight
    noc_bridge_pkg::axi_aw_t    cur_aw;
    logic [HDR_W-1:0]           exp_req_hdr;
    logic [`NOC_DATA_WIDTH-1:0] exp_data [0:7];
    logic [`NOC_STRB_WIDTH-1:0] exp_strb [0:7];

    noc_bridge_pkg::axi_aw_t    m_aw_q;
    noc_bridge_pkg::axi_w_t     m_w_q;
    noc_bridge_pkg::flit_t      req_flit_q;
    noc_bridge_pkg::flit_t      resp_flit_q;
    noc_bridge_pkg::flit_kind_e resp_kind_q;

    logic s_aw_fire_q;
    logic s_w_fire_q;
    logic s_b_fire_q;
    logic m_w_fire_q;
    logic m_b_fire_q;
    logic resp_fire_q;
    logic req_stall_q;
    logic resp_stall_q;
    logic resp_after_hdr;
    logic stim_started;
    logic timed_out;
    int   tgt_beat;
    int   errors;
    int   writes_done;

    axi_noc_bridge #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) i_dut (.*);

    // A closed gate stalls valid and ready together on each loopback
    assign req_flit_i        = req_flit_o;
    assign req_flit_valid_i  = req_flit_valid_o && req_gate;
    assign req_flit_ready_i  = req_flit_ready_o && req_gate;
    assign resp_flit_i       = resp_flit_o;
    assign resp_flit_valid_i = resp_flit_valid_o && resp_gate;
    assign resp_flit_ready_i = resp_flit_ready_o && resp_gate;

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    function automatic logic [`NOC_COORD_X_WIDTH-1:0] mesh_x_of(
        input logic [`NOC_ID_WIDTH-1:0] id
    );
        int col;
        col = ((id == '0) ? 15 : int'(id) - 1) % `NOC_MESH_X; // ID 16 wraps to 0
        return col[`NOC_COORD_X_WIDTH-1:0];
    endfunction

    function automatic logic [`NOC_COORD_Y_WIDTH-1:0] mesh_y_of(
        input logic [`NOC_ID_WIDTH-1:0] id
    );
        int row;
        row = ((id == '0) ? 15 : int'(id) - 1) / `NOC_MESH_X;
        return row[`NOC_COORD_Y_WIDTH-1:0];
    endfunction

    function automatic logic [HDR_W-1:0] hdr_fields(input noc_bridge_pkg::flit_t f);
        return {f.payload.hdr.dst_x, f.payload.hdr.dst_y, f.payload.hdr.src_x,
                f.payload.hdr.src_y, f.payload.hdr.packet_count};
    endfunction

    // --------------------
    // Checks
    // --------------------
    assert property (@(posedge ACLK) !stim_started |-> !(s_b_valid_o || m_aw_valid_o
        || m_w_valid_o || req_flit_valid_o || resp_flit_valid_o))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: s_b/m_aw/m_w/req_flit/resp_flit valid got %b expected 00000",
                 $time, {s_b_valid_o, m_aw_valid_o, m_w_valid_o, req_flit_valid_o,
                 resp_flit_valid_o});
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        req_flit_valid_o && req_flit_ready_i
            && req_flit_o.kind == noc_bridge_pkg::ROUTING_HEADER
        |-> hdr_fields(req_flit_o) == exp_req_hdr)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: req_flit_o header got %h expected %h",
                 $time, hdr_fields(req_flit_o), exp_req_hdr);
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_aw_valid_o && m_aw_ready_i |-> m_aw_o == cur_aw)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: m_aw_o got %h expected %h", $time, m_aw_o, cur_aw);
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_w_valid_o && m_w_ready_i |-> m_w_o.data == exp_data[tgt_beat]
            && m_w_o.strb == exp_strb[tgt_beat] && m_w_o.last == (tgt_beat == cur_aw.len))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: m_w_o got %h expected %h", $time, m_w_o,
                 {exp_data[tgt_beat], exp_strb[tgt_beat], tgt_beat == cur_aw.len});
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        resp_flit_valid_o && resp_flit_ready_i && !resp_after_hdr
        |-> resp_flit_o.kind == noc_bridge_pkg::ROUTING_HEADER
            && hdr_fields(resp_flit_o) == RESP_HDR)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: resp_flit_o header got %h expected %h",
                 $time, hdr_fields(resp_flit_o), RESP_HDR);
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        resp_flit_valid_o && resp_flit_ready_i && resp_after_hdr
        |-> resp_flit_o.kind == noc_bridge_pkg::B_SUBHEADER && resp_flit_o.last)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: resp_flit_o kind/last got %0d/%0b expected %0d/1",
                 $time, resp_flit_o.kind, resp_flit_o.last, noc_bridge_pkg::B_SUBHEADER);
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_b_valid_o && s_b_ready_i |-> s_b_o.id == cur_aw.id)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: s_b_o.id got %h expected %h", $time, s_b_o.id, cur_aw.id);
    end

    // A stalled flit must come back unchanged on the next edge
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        req_stall_q |-> req_flit_valid_o && req_flit_o == req_flit_q)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: req_flit_o/valid got %h/%0b expected %h/1",
                 $time, req_flit_o, req_flit_valid_o, req_flit_q);
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        resp_stall_q |-> resp_flit_valid_o && resp_flit_o == resp_flit_q)
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: resp_flit_o/valid got %h/%0b expected %h/1",
                 $time, resp_flit_o, resp_flit_valid_o, resp_flit_q);
    end

    always @(posedge ACLK) begin
        s_aw_fire_q  <= s_aw_valid_i && s_aw_ready_o;
        s_w_fire_q   <= s_w_valid_i && s_w_ready_o;
        s_b_fire_q   <= s_b_valid_o && s_b_ready_i;
        m_w_fire_q   <= m_w_valid_o && m_w_ready_i;
        m_b_fire_q   <= m_b_valid_i && m_b_ready_o;
        resp_fire_q  <= resp_flit_valid_o && resp_flit_ready_i;
        resp_kind_q  <= resp_flit_o.kind;
        req_stall_q  <= req_flit_valid_o && !req_flit_ready_i;
        resp_stall_q <= resp_flit_valid_o && !resp_flit_ready_i;
        req_flit_q   <= req_flit_o;
        resp_flit_q  <= resp_flit_o;
        m_w_q        <= m_w_o;
        if (m_aw_valid_o && m_aw_ready_i) begin
            m_aw_q <= m_aw_o;
        end
    end

    // --------------------
    // Target model
    // --------------------
    always @(negedge ACLK) begin
        if (ARESETn) begin
            if (resp_fire_q) begin
                resp_after_hdr = (resp_kind_q == noc_bridge_pkg::ROUTING_HEADER);
            end
            if (m_w_fire_q) begin
                tgt_beat = tgt_beat + 1;
                if (m_w_q.last) begin
                    m_b_i.id    = m_aw_q.id;
                    m_b_valid_i = 1'b1;
                end
            end
            if (m_b_fire_q) begin
                m_b_valid_i = 1'b0;
                tgt_beat    = 0;
            end
            m_aw_ready_i = ($urandom % 4) != 0;
            m_w_ready_i  = ($urandom % 4) != 0;
            req_gate     = ($urandom % 4) != 0;
            resp_gate    = ($urandom % 4) != 0;
        end
    end

    task automatic run_write(input int n);
        logic [31:0] rnd;
        int          beat;
        int          wait_cycles;
        logic        b_done;
        rnd          = $urandom;
        cur_aw.id    = rnd[`NOC_ID_WIDTH-1:0] + 1'b1;
        cur_aw.addr  = {rnd[`NOC_ADDR_WIDTH+3:6], 2'b00};
        cur_aw.len   = 8'(rnd[31:29]);
        cur_aw.size  = 3'd2;
        cur_aw.burst = 2'b01;
        for (int i = 0; i < 8; i++) begin
            rnd         = $urandom;
            exp_data[i] = $urandom;
            exp_strb[i] = rnd[`NOC_STRB_WIDTH-1:0];
        end
        exp_req_hdr = {mesh_x_of(cur_aw.id), mesh_y_of(cur_aw.id),
                       ROUTER_X[`NOC_COORD_X_WIDTH-1:0], ROUTER_Y[`NOC_COORD_Y_WIDTH-1:0],
                       cur_aw.len + 8'd2};
        beat         = 0;
        wait_cycles  = 0;
        b_done       = 1'b0;
        s_aw_i       = cur_aw;
        s_aw_valid_i = 1'b1;
        while (!b_done) begin
            if (!s_w_valid_i && beat <= int'(cur_aw.len) && ($urandom % 4) != 0) begin
                s_w_i.data  = exp_data[beat];
                s_w_i.strb  = exp_strb[beat];
                s_w_i.last  = (beat == int'(cur_aw.len));
                s_w_valid_i = 1'b1;
            end
            s_b_ready_i = ($urandom % 4) != 0;
            @(negedge ACLK);
            wait_cycles = wait_cycles + 1;
            if (s_aw_fire_q) begin
                s_aw_valid_i = 1'b0;
            end
            if (s_w_fire_q) begin
                s_w_valid_i = 1'b0;
                beat        = beat + 1;
            end
            b_done = s_b_fire_q;
            if (!b_done && wait_cycles > WAIT_LIMIT) begin
                $display("Timed out waiting for the write response of write %0d", n);
                timed_out = 1'b1;
                break;
            end
        end
        if (b_done) begin
            writes_done = writes_done + 1;
        end
        s_b_ready_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h4789_2d7f));
        ARESETn        = 1'b0;
        s_aw_i         = '0;
        s_aw_valid_i   = 1'b0;
        s_w_i          = '0;
        s_w_valid_i    = 1'b0;
        s_b_ready_i    = 1'b0;
        m_aw_ready_i   = 1'b0;
        m_w_ready_i    = 1'b0;
        m_b_i          = '0;
        m_b_valid_i    = 1'b0;
        req_gate       = 1'b0;
        resp_gate      = 1'b0;
        cur_aw         = '0;
        exp_req_hdr    = '0;
        tgt_beat       = 0;
        resp_after_hdr = 1'b0;
        stim_started   = 1'b0;
        timed_out      = 1'b0;
        errors         = 0;
        writes_done    = 0;
        repeat (10) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        repeat (3) @(negedge ACLK); // Idle window for the reset check
        stim_started = 1'b1;
        for (int n = 0; n < NUM_WRITES && !timed_out; n++) begin
            run_write(n);
        end
        repeat (4) @(negedge ACLK);
        $display("Writes completed: %0d of %0d, errors: %0d, timeouts: %0d",
                 writes_done, NUM_WRITES, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/noc_bridge_pkg.sv
design/write_req_packetizer.sv
design/write_req_depacketizer.sv
design/write_resp_packetizer.sv
design/write_resp_depacketizer.sv
design/axi_noc_bridge.sv
verification/tb_axi_noc_bridge.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_axi_noc_bridge --Mdir obj_dir -o tb_axi_noc_bridge
	./obj_dir/tb_axi_noc_bridge | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
